//--- axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model
	import vdma_pkg::*;
#(
	parameter int SEED = 26
) (
	input  wire        clk,
	input  wire        rst_n,

	// Stall control, 0 disables random stalls
	input  wire  [3:0] stall_max,
	input  wire        w_block,

	input  wire axi_aw_t aw,
	input  wire        awvalid,
	output logic       awready,
	input  wire axi_w_t  w,
	input  wire        wvalid,
	output logic       wready,
	output logic       bvalid,
	input  wire        bready
);

	logic [7:0]  mem [0:65535];
	logic        busy;
	logic        in_data;
	logic [15:0] wr_addr;
	logic [3:0]  stall_cnt;
	int          seed;
	int          draw;

	// Unwritten bytes hold a pattern of their full address
	initial begin
		seed = SEED;
		for (int i = 0; i < 65536; i++) begin
			mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;
		end
	end

	// One burst at a time, address taken only when idle
	assign awready = !busy;
	assign wready  = in_data && !w_block && (stall_cnt == 4'd0);

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			in_data   <= 1'b0;
			bvalid    <= 1'b0;
			wr_addr   <= '0;
			stall_cnt <= '0;
		end else begin
			if (awvalid && awready) begin
				busy    <= 1'b1;
				in_data <= 1'b1;
				wr_addr <= aw.addr[15:0];
			end
			if (wvalid && wready) begin
				for (int b = 0; b < DATA_WIDTH / 8; b++) begin
					if (w.strb[b]) begin
						mem[wr_addr + 16'(b)] <= w.data[8*b +: 8];
					end
				end
				wr_addr <= wr_addr + 16'(BYTES_PER_WORD);
				if (w.last) begin
					in_data <= 1'b0;
					bvalid  <= 1'b1;
				end
			end
			if (bvalid && bready) begin
				bvalid <= 1'b0;
				busy   <= 1'b0;
			end

			// Random wready stalls of 1 to stall_max cycles
			if (stall_cnt != 4'd0) begin
				stall_cnt <= stall_cnt - 1'b1;
			end else if (stall_max != 4'd0) begin
				draw = $random(seed);
				if (draw[1:0] == 2'b00) begin
					stall_cnt <= 4'(((draw >> 2) & 15) % int'(stall_max)) + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- fifo2mm.sv
`timescale 1ns/1ps
`default_nettype none

module fifo2mm
	import vdma_pkg::*;
#(
	parameter int BURST_LEN = 16,
	parameter int IMG_WBITS = 12,
	parameter int IMG_HBITS = 12
) (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   soft_resetn,
	output logic                  resetting,

	input  wire  [IMG_WBITS-1:0]  img_width,
	input  wire  [IMG_HBITS-1:0]  img_height,
	input  wire  [ADDR_WIDTH-1:0] base_addr,
	output logic                  sof_pulse,

	// FIFO head
	input  wire                   sof,
	input  wire  [DATA_WIDTH-1:0] din,
	input  wire                   empty,
	output logic                  rd_en,
	output logic                  flush,

	// AXI4 write master
	output axi_aw_t               aw,
	output logic                  awvalid,
	input  wire                   awready,
	output axi_w_t                w,
	output logic                  wvalid,
	input  wire                   wready,
	input  wire                   bvalid,
	output logic                  bready
);

	localparam int PIX_BITS  = IMG_WBITS + IMG_HBITS;
	localparam int WCNT_BITS = PIX_BITS - 2;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ADDR,
		ST_DATA,
		ST_RESP
	} state_t;

	state_t                state;
	logic [ADDR_WIDTH-1:0] addr_q;
	logic [WCNT_BITS-1:0]  words_left;
	logic [7:0]            beat_cnt;
	logic [7:0]            cur_len;
	logic [WCNT_BITS-1:0]  burst_words;
	logic                  last_burst;
	logic [PIX_BITS-1:0]   frame_pixels;
	logic [WCNT_BITS-1:0]  frame_words;
	logic                  frame_start;
	logic                  beat_done;

	assign frame_pixels = img_width * img_height;
	assign frame_words  = WCNT_BITS'(frame_pixels / PIXELS_PER_WORD);

	// Final burst carries whatever is left
	assign last_burst  = words_left <= WCNT_BITS'(BURST_LEN);
	assign cur_len     = last_burst ? 8'(words_left - 1'b1) : 8'(BURST_LEN - 1);
	assign burst_words = WCNT_BITS'(cur_len) + 1'b1;

	////////////////////////////////////////////////////////////////////////////
	// FIFO side
	////////////////////////////////////////////////////////////////////////////

	// Head word is inspected in place, not consumed
	assign frame_start = (state == ST_IDLE) && !empty && sof && !resetting;
	assign sof_pulse   = frame_start;
	assign beat_done   = wvalid && wready;

	// Idle drops words until a frame start shows up
	assign rd_en = ((state == ST_IDLE) && !empty && !sof && !resetting) || beat_done;
	assign flush = (state == ST_IDLE) && resetting;

	////////////////////////////////////////////////////////////////////////////
	// AXI channels
	////////////////////////////////////////////////////////////////////////////

	assign awvalid = state == ST_ADDR;
	assign wvalid  = (state == ST_DATA) && !empty;
	assign bready  = state == ST_RESP;

	always_comb begin
		aw.addr = addr_q;
		aw.len  = cur_len;
		aw.size = 3'($clog2(BYTES_PER_WORD));
		w.data  = din;
		w.strb  = '1;
		w.last  = beat_cnt == cur_len;
	end

	////////////////////////////////////////////////////////////////////////////
	// Burst FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			beat_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (frame_start) begin
						state <= ST_ADDR;
					end
				end
				ST_ADDR: begin
					if (awready) begin
						state    <= ST_DATA;
						beat_cnt <= '0;
					end
				end
				ST_DATA: begin
					if (beat_done) begin
						if (w.last) begin
							state <= ST_RESP;
						end else begin
							beat_cnt <= beat_cnt + 1'b1;
						end
					end
				end
				ST_RESP: begin
					// Soft reset abandons the frame once this burst is acknowledged
					if (bvalid) begin
						state <= (last_burst || resetting) ? ST_IDLE : ST_ADDR;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			words_left <= '0;
		end else if (frame_start) begin
			words_left <= frame_words;
		end else if (bready && bvalid) begin
			words_left <= words_left - burst_words;
		end
	end

	always_ff @(posedge clk) begin
		if (frame_start) begin
			addr_q <= base_addr;
		end else if (bready && bvalid) begin
			addr_q <= addr_q + ADDR_WIDTH'(burst_words * BYTES_PER_WORD);
		end
	end

	// Drain ends only once idle with the request released
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			resetting <= 1'b0;
		end else if (!soft_resetn) begin
			resetting <= 1'b1;
		end else if (state == ST_IDLE) begin
			resetting <= 1'b0;
		end
	end

	a_aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
		awvalid && !awready |=> awvalid && $stable(aw))
		else $error("fifo2mm: aw changed while stalled");

	// Last beat must match the len the slave accepted
	// Len holds from the address handshake on and the beat counter stays within it
	a_wlast_len: assert property (@(posedge clk) disable iff (!rst_n)
		state == ST_DATA |-> $stable(aw.len) && (beat_cnt <= aw.len))
		else $error("fifo2mm: wlast not on beat len");

endmodule

`default_nettype wire

//--- filelist.f
vdma_pkg.sv
pixel_fifo.sv
fifo2mm.sv
s2mm.sv
vdma_s2mm.sv
tb_clk_gen.sv
axi_mem_model.sv
tb_vdma_s2mm.sv

//--- pixel_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo
	import vdma_pkg::*;
#(
	parameter int FIFO_DEPTH = 64
) (
	input  wire             clk,
	input  wire             rst_n,
	input  wire             flush,

	input  wire             wr_en,
	input  wire pix_entry_t wr_data,
	output logic            full,

	input  wire             rd_en,
	output logic            empty,
	output fifo_word_t      rd_data
);

	localparam int PTR_BITS = $clog2(FIFO_DEPTH);
	localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);

	pix_entry_t          mem [FIFO_DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                do_wr;
	logic                do_rd;

	////////////////////////////////////////////////////////////////////////////
	// Flags
	////////////////////////////////////////////////////////////////////////////

	// A whole word must be present before the head is shown
	assign empty = count < CNT_BITS'(PIXELS_PER_WORD);
	// Keep room for one word so full drops on word boundaries
	assign full  = count > CNT_BITS'(FIFO_DEPTH - PIXELS_PER_WORD);

	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	////////////////////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// Read pointer is word aligned, so the four entries never wrap
	always_comb begin
		for (int i = 0; i < PIXELS_PER_WORD; i++) begin
			rd_data[i] = mem[rd_ptr + PTR_BITS'(i)];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				if (wr_ptr == PTR_BITS'(FIFO_DEPTH - 1)) begin
					wr_ptr <= '0;
				end else begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end
			if (do_rd) begin
				if (rd_ptr == PTR_BITS'(FIFO_DEPTH - PIXELS_PER_WORD)) begin
					rd_ptr <= '0;
				end else begin
					rd_ptr <= rd_ptr + PTR_BITS'(PIXELS_PER_WORD);
				end
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - CNT_BITS'(PIXELS_PER_WORD);
				2'b11:   count <= count + 1'b1 - CNT_BITS'(PIXELS_PER_WORD);
				default: count <= count;
			endcase
		end
	end

	// Both neighbours must honour the flags
	a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> !full)
		else $error("pixel_fifo: write while full");

	a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
		rd_en |-> !empty)
		else $error("pixel_fifo: read while empty");

endmodule

`default_nettype wire

//--- s2mm.sv
`timescale 1ns/1ps
`default_nettype none

module s2mm
	import vdma_pkg::*;
#(
	parameter int BURST_LEN = 16,
	parameter int IMG_WBITS = 12,
	parameter int IMG_HBITS = 12
) (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   soft_resetn,
	output logic                  resetting,
	input  wire  [IMG_WBITS-1:0]  img_width,
	input  wire  [IMG_HBITS-1:0]  img_height,
	input  wire  [ADDR_WIDTH-1:0] base_addr,
	output logic                  sof_pulse,

	// Pixel stream in
	input  wire                   s_axis_tvalid,
	input  wire [PIXEL_WIDTH-1:0] s_axis_tdata,
	input  wire                   s_axis_tuser,
	input  wire                   s_axis_tlast,
	output logic                  s_axis_tready,

	// FIFO write side
	input  wire                   full,
	output logic                  wr_en,
	output pix_entry_t            wr_data,

	// FIFO read side
	output logic                  flush,
	input  wire                   empty,
	input  wire fifo_word_t       rd_data,
	output logic                  rd_en,

	// AXI4 write master
	output axi_aw_t               aw,
	output logic                  awvalid,
	input  wire                   awready,
	output axi_w_t                w,
	output logic                  wvalid,
	input  wire                   wready,
	input  wire                   bvalid,
	output logic                  bready
);

	logic [DATA_WIDTH-1:0] pixel_data;

	////////////////////////////////////////////////////////////////////////////
	// Stream to FIFO
	////////////////////////////////////////////////////////////////////////////

	assign s_axis_tready = ~full;
	assign wr_en         = s_axis_tvalid && s_axis_tready;

	always_comb begin
		wr_data.last = s_axis_tlast;
		wr_data.user = s_axis_tuser;
		wr_data.data = s_axis_tdata;
	end

	a_tdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
		s_axis_tvalid && !s_axis_tready |=> s_axis_tvalid && $stable(s_axis_tdata))
		else $error("s2mm: tdata changed while stalled");

	////////////////////////////////////////////////////////////////////////////
	// FIFO to memory
	////////////////////////////////////////////////////////////////////////////

	// Strip flags, oldest pixel lands in the low byte lane
	always_comb begin
		for (int i = 0; i < PIXELS_PER_WORD; i++) begin
			pixel_data[i*PIXEL_WIDTH +: PIXEL_WIDTH] = rd_data[i].data;
		end
	end

	fifo2mm #(
		.BURST_LEN (BURST_LEN),
		.IMG_WBITS (IMG_WBITS),
		.IMG_HBITS (IMG_HBITS)
	) u_fifo2mm (
		.clk         (clk),
		.rst_n       (rst_n),
		.soft_resetn (soft_resetn),
		.resetting   (resetting),
		.img_width   (img_width),
		.img_height  (img_height),
		.base_addr   (base_addr),
		.sof_pulse   (sof_pulse),
		.sof         (rd_data[0].user),
		.din         (pixel_data),
		.empty       (empty),
		.rd_en       (rd_en),
		.flush       (flush),
		.aw          (aw),
		.awvalid     (awvalid),
		.awready     (awready),
		.w           (w),
		.wvalid      (wvalid),
		.wready      (wready),
		.bvalid      (bvalid),
		.bready      (bready)
	);

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Reset released on a rising edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

//--- tb_vdma_s2mm.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vdma_s2mm
	import vdma_pkg::*;
();

	localparam int BURST_LEN    = 4;
	localparam int FIFO_DEPTH   = 16;
	localparam int IMG_W        = 8;
	localparam int IMG_H        = 3;
	localparam int FRAME_PIX    = IMG_W * IMG_H;
	localparam int FRAME_WORDS  = FRAME_PIX / PIXELS_PER_WORD;
	localparam int FRAME_BURSTS = (FRAME_WORDS + BURST_LEN - 1) / BURST_LEN;
	// Six frames, worst case about 500 cycles each under stalls
	localparam int MAX_CYCLES   = 4000;

	logic                  clk;
	logic                  rst_n;
	logic                  soft_resetn;
	logic [11:0]           img_width;
	logic [11:0]           img_height;
	logic [ADDR_WIDTH-1:0] base_addr;
	logic                  s_axis_tvalid;
	logic [7:0]            s_axis_tdata;
	logic                  s_axis_tuser;
	logic                  s_axis_tlast;
	logic                  s_axis_tready;
	axi_aw_t               aw;
	logic                  awvalid;
	logic                  awready;
	axi_w_t                w;
	logic                  wvalid;
	logic                  wready;
	logic                  bvalid;
	logic                  bready;
	logic                  sof_pulse;
	logic                  resetting;
	logic [3:0]            stall_max;
	logic                  w_block;

	int         seed = 26;
	int         errors;
	int         tests;
	int         cycles;
	int         accepted;
	logic [7:0] exp_q [$];

	// Bus monitor state
	logic [31:0] exp_addr;
	int          words_left;
	logic [7:0]  exp_len;
	logic [7:0]  cur_len;
	int          beat_idx;
	int          outstanding;
	int          aw_count;
	int          w_count;
	int          b_count;
	int          sof_count;
	int          tready_low;
	logic        rst_q = 1'b0;
	logic        resetting_q;
	logic        post_rst;

	tb_clk_gen #(
		.PERIOD_NS    (10),
		.RESET_CYCLES (10)
	) u_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	vdma_s2mm #(
		.BURST_LEN  (BURST_LEN),
		.FIFO_DEPTH (FIFO_DEPTH),
		.IMG_WBITS  (12),
		.IMG_HBITS  (12)
	) u_dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.soft_resetn   (soft_resetn),
		.img_width     (img_width),
		.img_height    (img_height),
		.base_addr     (base_addr),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tdata  (s_axis_tdata),
		.s_axis_tuser  (s_axis_tuser),
		.s_axis_tlast  (s_axis_tlast),
		.s_axis_tready (s_axis_tready),
		.aw            (aw),
		.awvalid       (awvalid),
		.awready       (awready),
		.w             (w),
		.wvalid        (wvalid),
		.wready        (wready),
		.bvalid        (bvalid),
		.bready        (bready),
		.sof_pulse     (sof_pulse),
		.resetting     (resetting)
	);

	axi_mem_model #(
		.SEED (26)
	) u_mem (
		.clk       (clk),
		.rst_n     (rst_n),
		.stall_max (stall_max),
		.w_block   (w_block),
		.aw        (aw),
		.awvalid   (awvalid),
		.awready   (awready),
		.w         (w),
		.wvalid    (wvalid),
		.wready    (wready),
		.bvalid    (bvalid),
		.bready    (bready)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reference model of the burst sequence
	////////////////////////////////////////////////////////////////////////////

	assign exp_len = 8'(((words_left < BURST_LEN) ? words_left : BURST_LEN) - 1);

	always @(posedge clk) begin
		rst_q <= rst_n;
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exp_addr    <= '0;
			words_left  <= 0;
			cur_len     <= '0;
			beat_idx    <= 0;
			outstanding <= 0;
			aw_count    <= 0;
			w_count     <= 0;
			b_count     <= 0;
			sof_count   <= 0;
			tready_low  <= 0;
			resetting_q <= 1'b0;
			post_rst    <= 1'b0;
		end else begin
			if (sof_pulse) begin
				exp_addr   <= base_addr;
				words_left <= FRAME_WORDS;
				sof_count  <= sof_count + 1;
			end
			if (awvalid && awready) begin
				exp_addr    <= exp_addr + 32'((int'(exp_len) + 1) * BYTES_PER_WORD);
				words_left  <= words_left - (int'(exp_len) + 1);
				cur_len     <= exp_len;
				beat_idx    <= 0;
				outstanding <= outstanding + 1;
				aw_count    <= aw_count + 1;
			end
			if (wvalid && wready) begin
				beat_idx <= beat_idx + 1;
				w_count  <= w_count + 1;
			end
			if (bvalid && bready) begin
				outstanding <= outstanding - 1;
				b_count     <= b_count + 1;
			end
			if (s_axis_tvalid && !s_axis_tready) begin
				tready_low <= tready_low + 1;
			end
			resetting_q <= resetting;
			// Armed from the end of a drain until the next frame start
			if (sof_pulse) begin
				post_rst <= 1'b0;
			end else if (resetting_q && !resetting) begin
				post_rst <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Protocol checks
	////////////////////////////////////////////////////////////////////////////

	a_reset_values: assert property (@(posedge clk)
		(!rst_n || !rst_q) |-> !(awvalid || wvalid || bready || sof_pulse || resetting))
		else begin
			$display("Outputs not low during or just after reset");
			errors++;
		end

	a_aw_addr: assert property (@(posedge clk) disable iff (!rst_n)
		awvalid && awready |-> aw.addr == exp_addr)
		else begin
			$display("ERROR aw.addr expected %h actual %h", $sampled(exp_addr),
				$sampled(aw.addr));
			errors++;
		end

	a_aw_len: assert property (@(posedge clk) disable iff (!rst_n)
		awvalid && awready |-> aw.len == exp_len)
		else begin
			$display("ERROR aw.len expected %h actual %h", $sampled(exp_len),
				$sampled(aw.len));
			errors++;
		end

	// Four byte beats
	a_aw_size: assert property (@(posedge clk) disable iff (!rst_n)
		awvalid |-> aw.size == 3'd2)
		else begin
			$display("ERROR aw.size expected %h actual %h", 3'd2, $sampled(aw.size));
			errors++;
		end

	a_w_last: assert property (@(posedge clk) disable iff (!rst_n)
		wvalid && wready |-> w.last == (beat_idx == int'(cur_len)))
		else begin
			$display("ERROR w.last expected %h actual %h",
				$sampled(beat_idx == int'(cur_len)), $sampled(w.last));
			errors++;
		end

	a_w_strb: assert property (@(posedge clk) disable iff (!rst_n)
		wvalid |-> w.strb == 4'hF)
		else begin
			$display("ERROR w.strb expected %h actual %h", 4'hF, $sampled(w.strb));
			errors++;
		end

	a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
		awvalid |-> outstanding == 0)
		else begin
			$display("New burst requested before the previous response");
			errors++;
		end

	a_sof_single: assert property (@(posedge clk) disable iff (!rst_n)
		sof_pulse |=> !sof_pulse)
		else begin
			$display("sof_pulse lasted more than one cycle");
			errors++;
		end

	a_reset_rise: assert property (@(posedge clk) disable iff (!rst_n)
		!soft_resetn |=> resetting)
		else begin
			$display("resetting did not follow soft reset request");
			errors++;
		end

	a_drain_done: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(resetting) |-> outstanding == 0)
		else begin
			$display("resetting fell with a burst still open");
			errors++;
		end

	a_quiet_after_drain: assert property (@(posedge clk) disable iff (!rst_n)
		post_rst |-> !awvalid)
		else begin
			$display("Burst requested after soft reset before a new frame start");
			errors++;
		end

	a_no_start_resetting: assert property (@(posedge clk) disable iff (!rst_n)
		resetting |-> !sof_pulse)
		else begin
			$display("Frame started while resetting");
			errors++;
		end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [7:0] pixel_value(input int tag, input int n);
		return 8'(tag * 32 + n);
	endfunction

	function automatic logic [7:0] untouched_byte(input logic [15:0] a);
		return a[7:0] ^ a[15:8] ^ 8'h5A;
	endfunction

	task automatic send_pixel(input logic [7:0] data, input logic user, input logic last,
		input bit gaps);
		int r;
		if (gaps) begin
			r = $random(seed);
			if ((r & 3) == 0) begin
				s_axis_tvalid <= 1'b0;
				repeat (((r >> 2) & 3) + 1) @(posedge clk);
			end
		end
		s_axis_tvalid <= 1'b1;
		s_axis_tdata  <= data;
		s_axis_tuser  <= user;
		s_axis_tlast  <= last;
		@(posedge clk);
		while (!s_axis_tready) @(posedge clk);
		accepted++;
	endtask

	task automatic send_frame(input int tag, input bit gaps);
		for (int n = 0; n < FRAME_PIX; n++) begin
			exp_q.push_back(pixel_value(tag, n));
			send_pixel(pixel_value(tag, n), n == 0, (n % IMG_W) == IMG_W - 1, gaps);
		end
		s_axis_tvalid <= 1'b0;
		s_axis_tuser  <= 1'b0;
		s_axis_tlast  <= 1'b0;
	endtask

	// Pixels with no start of frame, never meant to reach memory
	task automatic send_junk(input int count);
		for (int n = 0; n < count; n++) begin
			send_pixel(8'hE0 + 8'(n), 1'b0, 1'b0, 1'b0);
		end
		s_axis_tvalid <= 1'b0;
	endtask

	task automatic wait_bursts(input int target);
		while (b_count < target) @(posedge clk);
	endtask

	task automatic check_frame(input logic [31:0] base, input int nbytes);
		logic [15:0] a;
		logic [7:0]  exp_b;
		for (int n = 0; n < nbytes; n++) begin
			a     = 16'(base + 32'(n));
			exp_b = exp_q.pop_front();
			assert (u_mem.mem[a] == exp_b) else begin
				$display("ERROR mem[%h] expected %h actual %h", a, exp_b, u_mem.mem[a]);
				errors++;
			end
		end
		exp_q.delete();
		// Nothing past the written part may change
		for (int n = nbytes; n < FRAME_PIX + 4; n++) begin
			a = 16'(base + 32'(n));
			assert (u_mem.mem[a] == untouched_byte(a)) else begin
				$display("ERROR mem[%h] expected %h actual %h", a, untouched_byte(a),
					u_mem.mem[a]);
				errors++;
			end
		end
	endtask

	task automatic check_count(input string what, input int actual, input int expected);
		assert (actual == expected) else begin
			$display("ERROR %s expected %h actual %h", what, expected, actual);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int err_start);
		tests++;
		$display("Test %0d %s: %0d errors", tests, name, errors - err_start);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
			$display("Checks failed");
			$finish;
		end
	end

	initial begin
		int err_start;
		int a0;
		int b0;
		int w0;
		int s0;
		int t0;
		int acc0;
		soft_resetn   = 1'b1;
		img_width     = 12'(IMG_W);
		img_height    = 12'(IMG_H);
		base_addr     = '0;
		s_axis_tvalid = 1'b0;
		s_axis_tdata  = '0;
		s_axis_tuser  = 1'b0;
		s_axis_tlast  = 1'b0;
		stall_max     = 4'd0;
		w_block       = 1'b0;
		errors        = 0;
		tests         = 0;
		cycles        = 0;
		accepted      = 0;

		wait (rst_n === 1'b1);
		repeat (2) @(posedge clk);
		end_test("reset values", 0);

		// Plain frame, no stalls
		err_start = errors;
		b0 = b_count;
		s0 = sof_count;
		base_addr <= 32'h1000;
		send_frame(1, 1'b0);
		wait_bursts(b0 + FRAME_BURSTS);
		check_frame(32'h1000, FRAME_PIX);
		check_count("sof_pulse count", sof_count - s0, 1);
		end_test("frame placement", err_start);

		// Stream gaps and short wready stalls
		err_start = errors;
		a0 = aw_count;
		b0 = b_count;
		w0 = w_count;
		base_addr <= 32'h1800;
		stall_max <= 4'd3;
		send_frame(2, 1'b1);
		wait_bursts(b0 + FRAME_BURSTS);
		check_frame(32'h1800, FRAME_PIX);
		check_count("aw requests", aw_count - a0, FRAME_BURSTS);
		check_count("w beats", w_count - w0, FRAME_WORDS);
		end_test("burst shape", err_start);

		// Long stalls against a continuous stream
		err_start = errors;
		b0 = b_count;
		w0 = w_count;
		t0 = tready_low;
		base_addr <= 32'h2800;
		stall_max <= 4'd12;
		w_block   <= 1'b1;
		fork
			send_frame(3, 1'b0);
			begin
				repeat (40) @(posedge clk);
				w_block <= 1'b0;
			end
		join
		wait_bursts(b0 + FRAME_BURSTS);
		stall_max <= 4'd0;
		check_frame(32'h2800, FRAME_PIX);
		check_count("w beats", w_count - w0, FRAME_WORDS);
		assert (tready_low > t0) else begin
			$display("s_axis_tready never dropped under back-pressure");
			errors++;
		end
		end_test("back-pressure", err_start);

		// Words ahead of the first tuser must be dropped
		err_start = errors;
		b0 = b_count;
		w0 = w_count;
		s0 = sof_count;
		base_addr <= 32'h2000;
		send_junk(8);
		send_frame(4, 1'b1);
		wait_bursts(b0 + FRAME_BURSTS);
		check_frame(32'h2000, FRAME_PIX);
		check_count("w beats", w_count - w0, FRAME_WORDS);
		check_count("sof_pulse count", sof_count - s0, 1);
		end_test("resync", err_start);

		// Soft reset mid frame, first burst completes
		err_start = errors;
		b0 = b_count;
		s0 = sof_count;
		acc0 = accepted;
		base_addr <= 32'h3000;
		fork
			send_frame(5, 1'b1);
			begin
				wait (accepted >= acc0 + 8);
				soft_resetn <= 1'b0;
			end
		join
		wait_bursts(b0 + 1);
		repeat (2) @(posedge clk);
		soft_resetn <= 1'b1;
		@(posedge clk);
		while (resetting) @(posedge clk);
		repeat (8) @(posedge clk);
		check_count("bursts of aborted frame", b_count - b0, 1);
		check_frame(32'h3000, BURST_LEN * BYTES_PER_WORD);
		b0 = b_count;
		base_addr <= 32'h4000;
		send_frame(6, 1'b0);
		wait_bursts(b0 + FRAME_BURSTS);
		check_frame(32'h4000, FRAME_PIX);
		check_count("sof_pulse count", sof_count - s0, 2);
		end_test("soft reset", err_start);

		repeat (4) @(posedge clk);
		$display("Tests run: %0d, errors: %0d", tests, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vdma_pkg.sv
`default_nettype none

package vdma_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Bus geometry
	////////////////////////////////////////////////////////////////////////////

	localparam int PIXEL_WIDTH     = 8;
	localparam int ADDR_WIDTH      = 32;
	localparam int DATA_WIDTH      = 32;
	localparam int PIXELS_PER_WORD = 4;
	// Address step of one beat
	localparam int BYTES_PER_WORD  = 4;

	////////////////////////////////////////////////////////////////////////////
	// Payload types
	////////////////////////////////////////////////////////////////////////////

	// One FIFO entry, stream flags travel with the pixel
	typedef struct packed {
		logic                   last;
		logic                   user;
		logic [PIXEL_WIDTH-1:0] data;
	} pix_entry_t;

	// Entry 0 is the oldest pixel of the word
	typedef pix_entry_t [PIXELS_PER_WORD-1:0] fifo_word_t;

	// Write address payload, burst type and id are fixed
	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
		logic [7:0]            len;
		logic [2:0]            size;
	} axi_aw_t;

	// Write data payload
	typedef struct packed {
		logic [DATA_WIDTH-1:0]   data;
		logic [DATA_WIDTH/8-1:0] strb;
		logic                    last;
	} axi_w_t;

endpackage

`default_nettype wire

//--- vdma_s2mm.sv
`timescale 1ns/1ps
`default_nettype none

module vdma_s2mm
	import vdma_pkg::*;
#(
	parameter int BURST_LEN  = 16,
	parameter int FIFO_DEPTH = 64,
	parameter int IMG_WBITS  = 12,
	parameter int IMG_HBITS  = 12
) (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   soft_resetn,
	input  wire  [IMG_WBITS-1:0]  img_width,
	input  wire  [IMG_HBITS-1:0]  img_height,
	input  wire  [ADDR_WIDTH-1:0] base_addr,

	// Pixel stream in
	input  wire                   s_axis_tvalid,
	input  wire [PIXEL_WIDTH-1:0] s_axis_tdata,
	input  wire                   s_axis_tuser,
	input  wire                   s_axis_tlast,
	output logic                  s_axis_tready,

	// AXI4 write master
	output axi_aw_t               aw,
	output logic                  awvalid,
	input  wire                   awready,
	output axi_w_t                w,
	output logic                  wvalid,
	input  wire                   wready,
	input  wire                   bvalid,
	output logic                  bready,

	output logic                  sof_pulse,
	output logic                  resetting
);

	logic       fifo_full;
	logic       fifo_wr_en;
	pix_entry_t fifo_wr_data;
	logic       fifo_flush;
	logic       fifo_empty;
	fifo_word_t fifo_rd_data;
	logic       fifo_rd_en;

	// Both sides of the pixel path, FIFO sits between them
	s2mm #(
		.BURST_LEN (BURST_LEN),
		.IMG_WBITS (IMG_WBITS),
		.IMG_HBITS (IMG_HBITS)
	) u_s2mm (
		.clk           (clk),
		.rst_n         (rst_n),
		.soft_resetn   (soft_resetn),
		.resetting     (resetting),
		.img_width     (img_width),
		.img_height    (img_height),
		.base_addr     (base_addr),
		.sof_pulse     (sof_pulse),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tdata  (s_axis_tdata),
		.s_axis_tuser  (s_axis_tuser),
		.s_axis_tlast  (s_axis_tlast),
		.s_axis_tready (s_axis_tready),
		.full          (fifo_full),
		.wr_en         (fifo_wr_en),
		.wr_data       (fifo_wr_data),
		.flush         (fifo_flush),
		.empty         (fifo_empty),
		.rd_data       (fifo_rd_data),
		.rd_en         (fifo_rd_en),
		.aw            (aw),
		.awvalid       (awvalid),
		.awready       (awready),
		.w             (w),
		.wvalid        (wvalid),
		.wready        (wready),
		.bvalid        (bvalid),
		.bready        (bready)
	);

	pixel_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.flush   (fifo_flush),
		.wr_en   (fifo_wr_en),
		.wr_data (fifo_wr_data),
		.full    (fifo_full),
		.rd_en   (fifo_rd_en),
		.empty   (fifo_empty),
		.rd_data (fifo_rd_data)
	);

endmodule

`default_nettype wire
